//--- include/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// entries in each of the two queue banks
`define ISSUE_QUEUE_DEPTH 16

// architectural integer registers
`define REG_COUNT 32

// width of one register value
`define DATA_WIDTH 32

`endif

//--- hw/issue_pkg.sv
`include "issue_config.svh"

package issue_pkg;

    // one register value
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // register number
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

    // program counter
    typedef logic [31:0] addr_t;

    // index into one queue bank
    typedef logic [$clog2(`ISSUE_QUEUE_DEPTH)-1:0] qidx_t;

    // coarse operation kind, enough for the pairing rules
    typedef enum logic [2:0] {
        OP_ALU,
        OP_MULDIV,
        OP_BRANCH,
        OP_JUMP,
        OP_LOAD
    } op_class_t;

    // decoder output, one instruction
    typedef struct packed {
        logic      valid;
        addr_t     pc;
        op_class_t op;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t rdst;
        logic      regwrite;
        word_t     imm;
    } decode_data_t;

    // issued instruction with its operands attached
    typedef struct packed {
        logic      valid;
        addr_t     pc;
        op_class_t op;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t rdst;
        logic      regwrite;
        word_t     imm;
        word_t     rd1;
        word_t     rd2;
        // delay slot of a branch issued in the first slot
        logic      is_slot;
    } issue_data_t;

endpackage

//--- hw/issue_cand_if.sv
`timescale 1ns/1ps

interface issue_cand_if (
    input logic clk,
    input logic rst_n
);
    import issue_pkg::*;

    // oldest entry at index 0
    decode_data_t [1:0] cand;
    // per candidate, consumed at the edge unless stalled
    logic [1:0]         issue_en;
    // second candidate goes out as a delay slot
    logic               is_slot;
    // heads move this cycle
    logic               advance;

    modport queue (output cand, output advance, input issue_en);
    modport check (input clk, input rst_n, input cand, output issue_en, output is_slot);
    modport sb (input cand, input issue_en, input is_slot, input advance);

endinterface

//--- hw/issue_queue.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  issue_pkg::decode_data_t [1:0] dec_data,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          pred_flush,
    output logic                          full,
    issue_cand_if.queue                   cand
);
    import issue_pkg::*;

    localparam int unsigned DEPTH = `ISSUE_QUEUE_DEPTH;
    // one slot per bank stays open so head == tail means empty
    localparam qidx_t FULL_LEVEL = qidx_t'(DEPTH - 2);

    // bank 0 even, bank 1 odd
    decode_data_t mem [2][DEPTH];
    qidx_t        head [2];
    qidx_t        tail [2];
    qidx_t        used [2];
    logic [1:0]   nonempty;
    // bank with the oldest entry
    logic         head_sel;
    // bank taking the next push
    logic         tail_sel;

    logic         push_ok;
    logic         push_any;
    logic         push_both;
    decode_data_t push_first;
    decode_data_t push_data [2];
    logic [1:0]   push_en;
    logic [1:0]   pop_en;

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            used[b] = tail[b] - head[b];
            nonempty[b] = (used[b] != '0);
        end
    end

    // fewer than two free slots in a bank
    assign full = (used[0] >= FULL_LEVEL) || (used[1] >= FULL_LEVEL);

    // oldest from head_sel bank, next one from the other bank
    always_comb begin
        cand.cand[0] = '0;
        cand.cand[1] = '0;
        if (nonempty[head_sel]) begin
            cand.cand[0] = mem[head_sel][head[head_sel]];
        end
        if (nonempty[~head_sel]) begin
            cand.cand[1] = mem[~head_sel][head[~head_sel]];
        end
    end

    assign cand.advance = !stall;

    // first candidate always sits in the head_sel bank
    assign pop_en[0] = head_sel ? cand.issue_en[1] : cand.issue_en[0];
    assign pop_en[1] = head_sel ? cand.issue_en[0] : cand.issue_en[1];

    // no push on stall or any flush
    assign push_ok = !stall && !flush && !pred_flush;
    assign push_any = dec_data[0].valid || dec_data[1].valid;
    assign push_both = dec_data[0].valid && dec_data[1].valid;
    // a lone valid entry goes first whichever lane it came on
    assign push_first = dec_data[0].valid ? dec_data[0] : dec_data[1];

    assign push_data[0] = tail_sel ? dec_data[1] : push_first;
    assign push_data[1] = tail_sel ? push_first : dec_data[1];
    assign push_en[0] = push_ok && (tail_sel ? push_both : push_any);
    assign push_en[1] = push_ok && (tail_sel ? push_any : push_both);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int b = 0; b < 2; b++) begin
                head[b] <= '0;
                tail[b] <= '0;
            end
            head_sel <= 1'b0;
            tail_sel <= 1'b0;
        end else begin
            if (!stall) begin
                for (int b = 0; b < 2; b++) begin
                    head[b] <= head[b] + qidx_t'(pop_en[b]);
                end
                // single pop hands the oldest to the other bank
                head_sel <= head_sel ^ (cand.issue_en[0] ^ cand.issue_en[1]);
            end
            if (pred_flush) begin
                // keep only the current head of each bank
                for (int b = 0; b < 2; b++) begin
                    tail[b] <= head[b] + qidx_t'(nonempty[b]);
                end
                tail_sel <= head_sel ^ (nonempty[0] ^ nonempty[1]);
            end else begin
                for (int b = 0; b < 2; b++) begin
                    tail[b] <= tail[b] + qidx_t'(push_en[b]);
                end
                tail_sel <= tail_sel ^ (push_en[0] ^ push_en[1]);
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (push_en[b]) begin
                mem[b][tail[b]] <= push_data[b];
            end
        end
    end

    // decoder must hold back while full is high
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_ok && push_any |-> !full);

endmodule

//--- hw/issue_pair_check.sv
`timescale 1ns/1ps

module issue_pair_check (
    issue_cand_if.check cand,
    input logic [1:0]   operand_ready
);
    import issue_pkg::*;

    decode_data_t c0;
    decode_data_t c1;
    logic         c0_ctrl;
    logic         c1_ctrl;
    logic         c1_raw;
    logic         mul_pair;
    logic         c1_ok;
    logic         en0;
    logic         en1;

    assign c0 = cand.cand[0];
    assign c1 = cand.cand[1];

    // branch or jump
    assign c0_ctrl = (c0.op == OP_BRANCH) || (c0.op == OP_JUMP);
    assign c1_ctrl = (c1.op == OP_BRANCH) || (c1.op == OP_JUMP);

    // second reads what the first writes
    assign c1_raw = c0.regwrite && (c0.rdst != '0) &&
                    ((c0.rdst == c1.ra1) || (c0.rdst == c1.ra2));

    // only one mul/div unit
    assign mul_pair = (c0.op == OP_MULDIV) && (c1.op == OP_MULDIV);

    // second could go on its own merits, control never in slot 1
    assign c1_ok = c1.valid && operand_ready[1] && !c1_ctrl;

    // branch waits for an issuable delay slot
    assign en0 = c0.valid && operand_ready[0] && (!c0_ctrl || c1_ok);

    // delay slot skips the raw and mul/div rules
    assign en1 = en0 && c1_ok && (c0_ctrl || (!c1_raw && !mul_pair));

    assign cand.issue_en = {en1, en0};
    assign cand.is_slot = en0 && c0_ctrl;

    // queue never shows a second candidate without a first
    a_pair_order: assert property (@(posedge cand.clk) disable iff (!cand.rst_n)
        cand.cand[1].valid |-> cand.cand[0].valid);

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  issue_pkg::reg_addr_t [3:0] raddr,
    output issue_pkg::word_t [3:0]     rdata,
    input  logic [1:0]                 wb_en,
    input  issue_pkg::reg_addr_t [1:0] wb_addr,
    input  issue_pkg::word_t [1:0]     wb_data
);
    import issue_pkg::*;

    // no storage for register 0
    word_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 1; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int r = 1; r < `REG_COUNT; r++) begin
                // port 1 has priority on a clash
                if (wb_en[1] && wb_addr[1] == reg_addr_t'(r)) begin
                    regs[r] <= wb_data[1];
                end else if (wb_en[0] && wb_addr[0] == reg_addr_t'(r)) begin
                    regs[r] <= wb_data[0];
                end
            end
        end
    end

    // four async read ports
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (raddr[k] == '0) begin
                rdata[k] = '0;
            end else begin
                rdata[k] = regs[raddr[k]];
            end
        end
    end

endmodule

//--- hw/operand_scoreboard.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module operand_scoreboard (
    input  logic                         clk,
    input  logic                         rst_n,
    issue_cand_if.sb                     cand,
    input  issue_pkg::word_t [3:0]       rf_rdata,
    input  logic [1:0]                   wb_en,
    input  issue_pkg::reg_addr_t [1:0]   wb_addr,
    input  issue_pkg::word_t [1:0]       wb_data,
    output logic [1:0]                   operand_ready,
    output issue_pkg::issue_data_t [1:0] iss_data
);
    import issue_pkg::*;

    // write pending per register
    logic [`REG_COUNT-1:0] busy;
    logic [`REG_COUNT-1:0] busy_next;
    // operand order c0.ra1, c0.ra2, c1.ra1, c1.ra2
    reg_addr_t [3:0]       src_addr;
    logic [3:0]            src_ready;
    word_t [3:0]           src_data;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            src_addr[k] = k[0] ? cand.cand[k / 2].ra2 : cand.cand[k / 2].ra1;
        end
    end

    // same-cycle writeback beats the register file, port 1 last
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            src_data[k] = rf_rdata[k];
            src_ready[k] = (src_addr[k] == '0) || !busy[src_addr[k]];
            for (int p = 0; p < 2; p++) begin
                if (wb_en[p] && wb_addr[p] == src_addr[k] && src_addr[k] != '0) begin
                    src_data[k] = wb_data[p];
                    src_ready[k] = 1'b1;
                end
            end
        end
    end

    assign operand_ready[0] = src_ready[0] && src_ready[1];
    assign operand_ready[1] = src_ready[2] && src_ready[3];

    // writebacks clear, then issues set
    always_comb begin
        busy_next = busy;
        for (int p = 0; p < 2; p++) begin
            if (wb_en[p]) begin
                busy_next[wb_addr[p]] = 1'b0;
            end
        end
        if (cand.advance) begin
            for (int i = 0; i < 2; i++) begin
                if (cand.issue_en[i] && cand.cand[i].regwrite) begin
                    busy_next[cand.cand[i].rdst] = 1'b1;
                end
            end
        end
        // r0 never pending
        busy_next[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    // issued records, all zero when not issued
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            iss_data[i] = '0;
            if (cand.issue_en[i]) begin
                iss_data[i].valid = cand.cand[i].valid;
                iss_data[i].pc = cand.cand[i].pc;
                iss_data[i].op = cand.cand[i].op;
                iss_data[i].ra1 = cand.cand[i].ra1;
                iss_data[i].ra2 = cand.cand[i].ra2;
                iss_data[i].rdst = cand.cand[i].rdst;
                iss_data[i].regwrite = cand.cand[i].regwrite;
                iss_data[i].imm = cand.cand[i].imm;
                iss_data[i].rd1 = src_data[2 * i];
                iss_data[i].rd2 = src_data[2 * i + 1];
            end
        end
        iss_data[1].is_slot = cand.is_slot;
    end

    // every writeback matches an earlier issue that marked it busy
    for (genvar p = 0; p < 2; p++) begin : g_wb_check
        a_wb_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
            wb_en[p] && wb_addr[p] != '0 |-> busy[wb_addr[p]]);
    end

endmodule

//--- hw/issue_stage_top.sv
`timescale 1ns/1ps

module issue_stage_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  issue_pkg::decode_data_t [1:0] dec_data,
    input  logic                         stall,
    input  logic                         flush,
    input  logic                         pred_flush,
    output logic                         full,
    output issue_pkg::issue_data_t [1:0] iss_data,
    input  logic [1:0]                   wb_en,
    input  issue_pkg::reg_addr_t [1:0]   wb_addr,
    input  issue_pkg::word_t [1:0]       wb_data
);
    import issue_pkg::*;

    logic [1:0]      operand_ready;
    reg_addr_t [3:0] rf_raddr;
    word_t [3:0]     rf_rdata;

    issue_cand_if cand_if (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_queue i_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_data   (dec_data),
        .stall      (stall),
        .flush      (flush),
        .pred_flush (pred_flush),
        .full       (full),
        .cand       (cand_if.queue)
    );

    issue_pair_check i_pair_check (
        .cand          (cand_if.check),
        .operand_ready (operand_ready)
    );

    // read ports follow the scoreboard operand order
    assign rf_raddr[0] = cand_if.cand[0].ra1;
    assign rf_raddr[1] = cand_if.cand[0].ra2;
    assign rf_raddr[2] = cand_if.cand[1].ra1;
    assign rf_raddr[3] = cand_if.cand[1].ra2;

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr   (rf_raddr),
        .rdata   (rf_rdata),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    operand_scoreboard i_scoreboard (
        .clk           (clk),
        .rst_n         (rst_n),
        .cand          (cand_if.sb),
        .rf_rdata      (rf_rdata),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .operand_ready (operand_ready),
        .iss_data      (iss_data)
    );

endmodule

//--- tests/tb_issue_stage.sv
`timescale 1ns/1ps

module tb_issue_stage;
    import issue_pkg::*;

    // one table row, inputs for one cycle and the outputs seen before the next edge
    typedef struct packed {
        decode_data_t [1:0] dec;
        logic               stall;
        logic               flush;
        logic               pred_flush;
        logic [1:0]         wb_en;
        reg_addr_t [1:0]    wb_addr;
        word_t [1:0]        wb_data;
        // pc 0 means no issue in that slot
        addr_t [1:0]        exp_pc;
        word_t [1:0]        exp_rd1;
        word_t [1:0]        exp_rd2;
        logic               exp_slot;
        logic               exp_full;
    } row_t;

    logic                clk;
    logic                rst_n;
    decode_data_t [1:0]  dec_data;
    logic                stall;
    logic                flush;
    logic                pred_flush;
    logic                full;
    issue_data_t [1:0]   iss_data;
    logic [1:0]          wb_en;
    reg_addr_t [1:0]     wb_addr;
    word_t [1:0]         wb_data;

    row_t  rows[$];
    row_t  cur;
    // every instruction built, looked up by pc
    decode_data_t instr_of_pc [addr_t];
    int    errors;
    int    cycles;

    issue_stage_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_data   (dec_data),
        .stall      (stall),
        .flush      (flush),
        .pred_flush (pred_flush),
        .full       (full),
        .iss_data   (iss_data),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    always #50 clk = ~clk;

    // hard limit, table length plus reset and margin
    always @(posedge clk) begin
        cycles++;
        if (cycles > rows.size() + 20) begin
            $display("timeout: run did not finish within %0d cycles", rows.size() + 20);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // value written back into register r
    function automatic word_t wb_value(input int r);
        return 32'hc0de_0000 + word_t'(r);
    endfunction

    function automatic decode_data_t make_instr(input addr_t pc, input op_class_t op,
                                                input reg_addr_t ra1, input reg_addr_t ra2,
                                                input reg_addr_t rdst, input logic rw);
        decode_data_t d;
        d = '0;
        d.valid = 1'b1;
        d.pc = pc;
        d.op = op;
        d.ra1 = ra1;
        d.ra2 = ra2;
        d.rdst = rdst;
        d.regwrite = rw;
        d.imm = $urandom;
        instr_of_pc[pc] = d;
        return d;
    endfunction

    task automatic set_wb(input int p, input reg_addr_t a, input word_t d);
        cur.wb_en[p] = 1'b1;
        cur.wb_addr[p] = a;
        cur.wb_data[p] = d;
    endtask

    task automatic expect_iss(input int i, input addr_t pc, input word_t rd1, input word_t rd2);
        cur.exp_pc[i] = pc;
        cur.exp_rd1[i] = rd1;
        cur.exp_rd2[i] = rd2;
    endtask

    task automatic add_row();
        rows.push_back(cur);
        cur = '0;
    endtask

    task automatic build_table();
        // writer pair for r1 and r2, then their writebacks
        cur.dec[0] = make_instr(32'h100, OP_ALU, 0, 0, 1, 1);
        cur.dec[1] = make_instr(32'h104, OP_ALU, 0, 0, 2, 1);
        add_row();
        expect_iss(0, 32'h100, 0, 0);
        expect_iss(1, 32'h104, 0, 0);
        add_row();
        set_wb(0, 1, wb_value(1));
        set_wb(1, 2, wb_value(2));
        add_row();
        // independent pair goes out together
        cur.dec[0] = make_instr(32'h200, OP_ALU, 1, 2, 3, 1);
        cur.dec[1] = make_instr(32'h204, OP_ALU, 2, 1, 4, 1);
        add_row();
        expect_iss(0, 32'h200, wb_value(1), wb_value(2));
        expect_iss(1, 32'h204, wb_value(2), wb_value(1));
        add_row();
        // second reads r5 written by the first
        cur.dec[0] = make_instr(32'h300, OP_ALU, 1, 0, 5, 1);
        cur.dec[1] = make_instr(32'h304, OP_ALU, 5, 2, 6, 1);
        set_wb(0, 3, wb_value(3));
        set_wb(1, 4, wb_value(4));
        add_row();
        expect_iss(0, 32'h300, wb_value(1), 0);
        add_row();
        // r5 still pending
        add_row();
        // forwarded from the writeback port
        set_wb(0, 5, wb_value(5));
        expect_iss(0, 32'h304, wb_value(5), wb_value(2));
        add_row();
        // branch and delay slot in one push
        cur.dec[0] = make_instr(32'h400, OP_BRANCH, 1, 2, 0, 0);
        cur.dec[1] = make_instr(32'h404, OP_ALU, 2, 0, 7, 1);
        set_wb(0, 6, wb_value(6));
        add_row();
        expect_iss(0, 32'h400, wb_value(1), wb_value(2));
        expect_iss(1, 32'h404, wb_value(2), 0);
        cur.exp_slot = 1'b1;
        add_row();
        // lone jump waits for its slot
        cur.dec[0] = make_instr(32'h500, OP_JUMP, 0, 0, 0, 0);
        set_wb(0, 7, wb_value(7));
        add_row();
        // slot arrives on lane 1 alone
        cur.dec[1] = make_instr(32'h504, OP_ALU, 1, 0, 8, 1);
        add_row();
        expect_iss(0, 32'h500, 0, 0);
        expect_iss(1, 32'h504, wb_value(1), 0);
        cur.exp_slot = 1'b1;
        add_row();
        // branch behind an ALU op
        cur.dec[0] = make_instr(32'h600, OP_ALU, 1, 2, 9, 1);
        cur.dec[1] = make_instr(32'h604, OP_BRANCH, 1, 0, 0, 0);
        set_wb(0, 8, wb_value(8));
        add_row();
        cur.dec[0] = make_instr(32'h608, OP_ALU, 2, 0, 10, 1);
        expect_iss(0, 32'h600, wb_value(1), wb_value(2));
        add_row();
        set_wb(0, 9, wb_value(9));
        expect_iss(0, 32'h604, wb_value(1), 0);
        expect_iss(1, 32'h608, wb_value(2), 0);
        cur.exp_slot = 1'b1;
        add_row();
        // mul/div pair splits over two cycles
        cur.dec[0] = make_instr(32'h700, OP_MULDIV, 1, 2, 11, 1);
        cur.dec[1] = make_instr(32'h704, OP_MULDIV, 2, 1, 12, 1);
        set_wb(0, 10, wb_value(10));
        add_row();
        expect_iss(0, 32'h700, wb_value(1), wb_value(2));
        add_row();
        set_wb(0, 11, wb_value(11));
        expect_iss(0, 32'h704, wb_value(2), wb_value(1));
        add_row();
        // stall holds the pair on the outputs
        cur.dec[0] = make_instr(32'h800, OP_ALU, 1, 0, 13, 1);
        cur.dec[1] = make_instr(32'h804, OP_ALU, 2, 0, 14, 1);
        set_wb(0, 12, wb_value(12));
        add_row();
        for (int n = 0; n < 3; n++) begin
            cur.stall = (n < 2);
            // dropped, the queue takes nothing while stalled
            if (n == 1) begin
                cur.dec[0] = make_instr(32'h880, OP_ALU, 0, 0, 0, 0);
            end
            expect_iss(0, 32'h800, wb_value(1), 0);
            expect_iss(1, 32'h804, wb_value(2), 0);
            add_row();
        end
        // r13 left pending so the head cannot issue
        set_wb(1, 14, wb_value(14));
        add_row();
        for (int n = 0; n < 14; n++) begin
            cur.dec[0] = make_instr(32'h900 + 8 * n, OP_ALU, 13, 0, 0, 0);
            cur.dec[1] = make_instr(32'h904 + 8 * n, OP_ALU, 13, 0, 0, 0);
            add_row();
        end
        // 14 used per bank
        cur.exp_full = 1'b1;
        add_row();
        cur.pred_flush = 1'b1;
        cur.exp_full = 1'b1;
        add_row();
        // only the oldest pair is left
        set_wb(0, 13, wb_value(13));
        expect_iss(0, 32'h900, wb_value(13), 0);
        expect_iss(1, 32'h904, wb_value(13), 0);
        add_row();
        add_row();
        // lone branch, then flush
        cur.dec[0] = make_instr(32'ha00, OP_BRANCH, 1, 0, 0, 0);
        add_row();
        cur.flush = 1'b1;
        add_row();
        cur.dec[0] = make_instr(32'hb00, OP_ALU, 1, 2, 0, 0);
        add_row();
        // no stale branch ahead of it
        expect_iss(0, 32'hb00, wb_value(1), wb_value(2));
        add_row();
        add_row();
    endtask

    task automatic apply_row(input row_t r);
        dec_data = r.dec;
        stall = r.stall;
        flush = r.flush;
        pred_flush = r.pred_flush;
        wb_en = r.wb_en;
        wb_addr = r.wb_addr;
        wb_data = r.wb_data;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_row(input row_t r);
        addr_t        pc;
        logic         vld;
        decode_data_t exp_i;
        for (int i = 0; i < 2; i++) begin
            pc = r.exp_pc[i];
            vld = (pc != '0);
            exp_i = '0;
            if (vld) begin
                exp_i = instr_of_pc[pc];
            end
            check_value($sformatf("iss_data[%0d].valid", i), iss_data[i].valid, vld);
            check_value($sformatf("iss_data[%0d].pc", i), iss_data[i].pc, pc);
            check_value($sformatf("iss_data[%0d].op", i), iss_data[i].op, exp_i.op);
            check_value($sformatf("iss_data[%0d].ra1", i), iss_data[i].ra1, exp_i.ra1);
            check_value($sformatf("iss_data[%0d].ra2", i), iss_data[i].ra2, exp_i.ra2);
            check_value($sformatf("iss_data[%0d].rdst", i), iss_data[i].rdst, exp_i.rdst);
            check_value($sformatf("iss_data[%0d].regwrite", i), iss_data[i].regwrite,
                        exp_i.regwrite);
            check_value($sformatf("iss_data[%0d].imm", i), iss_data[i].imm, exp_i.imm);
            check_value($sformatf("iss_data[%0d].rd1", i), iss_data[i].rd1, r.exp_rd1[i]);
            check_value($sformatf("iss_data[%0d].rd2", i), iss_data[i].rd2, r.exp_rd2[i]);
        end
        check_value("iss_data[0].is_slot", iss_data[0].is_slot, 1'b0);
        check_value("iss_data[1].is_slot", iss_data[1].is_slot, r.exp_slot);
        check_value("full", full, r.exp_full);
    endtask

    initial begin
        void'($urandom(32'h805ac2a5));
        clk = 1'b0;
        rst_n = 1'b0;
        errors = 0;
        cycles = 0;
        cur = '0;
        apply_row(cur);
        build_table();
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        foreach (rows[r]) begin
            apply_row(rows[r]);
            // sample well before the next edge
            #80;
            compare_row(rows[r]);
            @(posedge clk);
            #10;
        end
        $display("run finished: %0d rows, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hw/issue_pkg.sv
hw/issue_cand_if.sv
hw/issue_queue.sv
hw/issue_pair_check.sv
hw/reg_file.sv
hw/operand_scoreboard.sv
hw/issue_stage_top.sv
tests/tb_issue_stage.sv

//--- Bender.yml
package:
  name: issue_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/issue_pkg.sv
      - hw/issue_cand_if.sv
      - hw/issue_queue.sv
      - hw/issue_pair_check.sv
      - hw/reg_file.sv
      - hw/operand_scoreboard.sv
      - hw/issue_stage_top.sv
  - target: test
    files:
      - tests/tb_issue_stage.sv
